// ==== hw/wr_join_pkg.sv ====
`default_nettype none

package wr_join_pkg;

    // Bus widths
    localparam int ADDR_W = 12;          // Byte address
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;  // One strobe per byte lane

    // Byte offset inside a data word, dropped to form the word index
    localparam int OFFS_W = $clog2(STRB_W);
    localparam int WORD_W = ADDR_W - OFFS_W;

    // Slot counts, each FIFO holds one beat fewer than this
    localparam int AW_DEPTH = 4;  // 3 address beats
    localparam int W_DEPTH  = 3;  // 2 data beats

    // First byte address past the slave window
    localparam logic [ADDR_W-1:0] WINDOW_LIMIT = 'h800;

    // Address channel beat
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } aw_beat_t;

    // Write data channel beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;  // Byte enables
    } w_beat_t;

    // Joined request toward the memory side
    typedef struct packed {
        logic [WORD_W-1:0] word_idx;  // Word address
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              err;       // Misaligned or outside window
    } wr_req_t;

endpackage : wr_join_pkg

`default_nettype wire

// ==== hw/fifo_0r0w.sv ====
`timescale 1ns/1ps
`default_nettype none

// Circular buffer with combinational head
// Writes land at the clock edge; while empty the input beat is passed
// straight to the head so a push and pop in one cycle costs no latency
// Pushing while full or popping while empty is not allowed
module fifo_0r0w #(
    parameter type payload_t = logic [7:0],  // Beat type of one slot
    parameter int  DEPTH     = 4             // Slot count, capacity is DEPTH-1
) (
    input  logic     i_clk,
    input  logic     i_rst_n,

    // Write side
    input  logic     i_push,
    output logic     o_full,
    input  payload_t i_wdata,

    // Read side
    input  logic     i_pop,
    output logic     o_empty,
    output payload_t o_rdata
);

    // At least one index bit even for a single slot
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem [DEPTH];   // Slot storage
    logic [IDX_W-1:0] push_idx;      // Next slot to write
    logic [IDX_W-1:0] pop_idx;       // Current head slot
    logic [IDX_W-1:0] push_idx_nxt;
    logic [IDX_W-1:0] pop_idx_nxt;
    logic             idx_equal;     // Nothing stored

    // Index advance, explicit wrap so DEPTH need not be a power of two
    always_comb begin
        if (push_idx == IDX_W'(DEPTH - 1)) begin
            push_idx_nxt = '0;
        end else begin
            push_idx_nxt = push_idx + IDX_W'(1);
        end

        if (pop_idx == IDX_W'(DEPTH - 1)) begin
            pop_idx_nxt = '0;
        end else begin
            pop_idx_nxt = pop_idx + IDX_W'(1);
        end
    end

    assign idx_equal = (push_idx == pop_idx);

    // One more push would make the indices meet; a pop frees a slot now
    assign o_full  = (push_idx_nxt == pop_idx) & ~i_pop;
    // Incoming beat counts as the head straight away
    assign o_empty = idx_equal & ~i_push;

    // Head mux, input bypass while nothing is stored
    // Also keeps the head steady when a pushed beat is not popped
    assign o_rdata = idx_equal ? i_wdata : mem[pop_idx];

    // Control state
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            push_idx <= '0;
            pop_idx  <= '0;
        end else begin
            if (i_push) begin
                push_idx <= push_idx_nxt;
            end
            if (i_pop) begin
                pop_idx <= pop_idx_nxt;
            end
        end
    end

    // Payload storage, no reset needed
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[push_idx] <= i_wdata;  // Written even when forwarded, harmless
        end
    end

endmodule : fifo_0r0w

`default_nettype wire

// ==== hw/write_joiner.sv ====
`timescale 1ns/1ps
`default_nettype none

// Joins the address head and the data head into one write request
// Pure combinational path, the FIFOs in front hold all state
// Beats pair strictly in arrival order: the n-th address goes with the
// n-th data beat, since both heads leave together on a single pop
module write_joiner (
    // Address FIFO head
    input  wr_join_pkg::aw_beat_t i_aw_head,
    input  logic                  i_aw_empty,

    // Data FIFO head
    input  wr_join_pkg::w_beat_t  i_w_head,
    input  logic                  i_w_empty,

    // Request handshake
    input  logic                  i_req_ready,
    output logic                  o_pop,        // Shared by both FIFOs
    output wr_join_pkg::wr_req_t  o_req,
    output logic                  o_req_valid
);

    import wr_join_pkg::*;

    logic [ADDR_W-1:0] addr;           // Head byte address
    logic [OFFS_W-1:0] byte_offs;      // Offset inside the word
    logic [WORD_W-1:0] word_idx;
    logic              misaligned;
    logic              out_of_window;
    logic              both_present;   // A full pair is waiting

    // Address split
    assign addr      = i_aw_head.addr;
    assign byte_offs = addr[OFFS_W-1:0];
    assign word_idx  = addr[ADDR_W-1:OFFS_W];

    // Error decode
    // Any nonzero low bit breaks word alignment
    assign misaligned    = |byte_offs;
    // Window runs from 0 up to, not including, the limit
    assign out_of_window = (addr >= WINDOW_LIMIT);

    // Pairing
    // Only a complete pair is offered, a lone beat waits in its FIFO
    assign both_present = ~i_aw_empty & ~i_w_empty;

    // Request assembly
    always_comb begin
        o_req          = '0;
        o_req.word_idx = word_idx;
        o_req.data     = i_w_head.data;   // Data passed through as is
        o_req.strb     = i_w_head.strb;
        o_req.err      = misaligned | out_of_window;  // Still forwarded, flagged only
    end

    // Handshake
    assign o_req_valid = both_present;
    // Both heads retire together on acceptance, keeps the pairing in step
    assign o_pop       = both_present & i_req_ready;

endmodule : write_joiner

`default_nettype wire

// ==== hw/wr_join_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Write channel join stage
// Address and data channels are buffered side by side, then paired
module wr_join_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Write address channel
    input  wr_join_pkg::aw_beat_t i_aw,
    input  logic                  i_aw_valid,
    output logic                  o_aw_ready,

    // Write data channel
    input  wr_join_pkg::w_beat_t  i_w,
    input  logic                  i_w_valid,
    output logic                  o_w_ready,

    // Joined request
    output wr_join_pkg::wr_req_t  o_req,
    output logic                  o_req_valid,
    input  logic                  i_req_ready
);

    import wr_join_pkg::*;

    // Address buffer side
    aw_beat_t aw_head;
    logic     aw_push;
    logic     aw_full;
    logic     aw_empty;

    // Data buffer side
    w_beat_t  w_head;
    logic     w_push;
    logic     w_full;
    logic     w_empty;

    logic     pop;  // Joiner retires both heads at once

    // Valid/ready onto push/full
    // Ready may follow i_req_ready within the cycle through the pop path
    assign o_aw_ready = ~aw_full;
    assign aw_push    = i_aw_valid & o_aw_ready;
    assign o_w_ready  = ~w_full;
    assign w_push     = i_w_valid & o_w_ready;

    fifo_0r0w #(
        .payload_t (aw_beat_t),
        .DEPTH     (AW_DEPTH)
    ) aw_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (aw_push),
        .o_full  (aw_full),
        .i_wdata (i_aw),
        .i_pop   (pop),
        .o_empty (aw_empty),
        .o_rdata (aw_head)
    );

    fifo_0r0w #(
        .payload_t (w_beat_t),
        .DEPTH     (W_DEPTH)
    ) w_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (w_push),
        .o_full  (w_full),
        .i_wdata (i_w),
        .i_pop   (pop),
        .o_empty (w_empty),
        .o_rdata (w_head)
    );

    write_joiner joiner (
        .i_aw_head   (aw_head),
        .i_aw_empty  (aw_empty),
        .i_w_head    (w_head),
        .i_w_empty   (w_empty),
        .i_req_ready (i_req_ready),
        .o_pop       (pop),
        .o_req       (o_req),
        .o_req_valid (o_req_valid)
    );

endmodule : wr_join_top

`default_nettype wire

// ==== sim/wr_join_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the FIFO control and the request port
module wr_join_assertions (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_aw_push,   // Address FIFO write
    input  logic                 i_w_push,    // Data FIFO write
    input  logic                 i_pop,       // Shared pop of both FIFOs
    input  wr_join_pkg::wr_req_t i_req,
    input  logic                 i_req_valid,
    input  logic                 i_req_ready
);

    import wr_join_pkg::*;

    // Beats held in each FIFO, rebuilt from the push and pop strobes
    int aw_count;
    int w_count;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            aw_count <= 0;
            w_count  <= 0;
        end else begin
            aw_count <= aw_count + int'(i_aw_push) - int'(i_pop);
            w_count  <= w_count + int'(i_w_push) - int'(i_pop);
        end
    end

    // Overflow on either buffer, a pop in the same cycle frees a slot
    aw_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_aw_push |-> (aw_count < AW_DEPTH - 1 || i_pop))
        else $error("address FIFO pushed while full");

    w_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_w_push |-> (w_count < W_DEPTH - 1 || i_pop))
        else $error("data FIFO pushed while full");

    // Underflow, a pop needs a stored or forwarded beat in both FIFOs
    no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> ((aw_count > 0 || i_aw_push) && (w_count > 0 || i_w_push)))
        else $error("FIFO popped while empty");

    // Stalled request holds valid and payload
    req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_req_valid && !i_req_ready) |=> (i_req_valid && $stable(i_req)))
        else $error("stalled request changed");

endmodule : wr_join_assertions

bind wr_join_top wr_join_assertions wr_join_assertions_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_aw_push   (aw_push),
    .i_w_push    (w_push),
    .i_pop       (pop),
    .i_req       (o_req),
    .i_req_valid (o_req_valid),
    .i_req_ready (i_req_ready)
);

`default_nettype wire

// ==== sim/wr_join_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wr_join_tb;

    import wr_join_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MON_DLY    = 30;   // Scoreboard sample point after the falling edge
    localparam int SAMPLE_DLY = 40;   // Check point, after the scoreboard
    localparam int TIMEOUT    = 64;   // Cycles allowed per wait
    localparam int RAND_BEATS = 200;

    logic     i_clk;
    logic     i_rst_n;
    aw_beat_t i_aw;
    logic     i_aw_valid;
    logic     o_aw_ready;
    w_beat_t  i_w;
    logic     i_w_valid;
    logic     o_w_ready;
    wr_req_t  o_req;
    logic     o_req_valid;
    logic     i_req_ready;

    // Scoreboard
    aw_beat_t aw_q[$];    // Accepted addresses not yet paired
    w_beat_t  w_q[$];     // Accepted data beats not yet paired
    wr_req_t  exp_q[$];   // Expected requests in order
    aw_beat_t mon_aw;
    w_beat_t  mon_w;
    int       error_count;
    int       req_count;
    int       test_count;
    int       failed_tests;
    int       test_start_errors;

    wr_join_top wr_join_top_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_aw        (i_aw),
        .i_aw_valid  (i_aw_valid),
        .o_aw_ready  (o_aw_ready),
        .i_w         (i_w),
        .i_w_valid   (i_w_valid),
        .o_w_ready   (o_w_ready),
        .o_req       (o_req),
        .o_req_valid (o_req_valid),
        .i_req_ready (i_req_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Word index drops the byte offset, err on misalignment or past the window
    function automatic wr_req_t expect_req(input aw_beat_t aw, input w_beat_t w);
        wr_req_t r;
        r.word_idx = aw.addr[ADDR_W-1:2];
        r.data     = w.data;
        r.strb     = w.strb;
        r.err      = (aw.addr[1:0] != 2'b00) || (aw.addr >= WINDOW_LIMIT);
        return r;
    endfunction

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_req(input string name, input wr_req_t got, input wr_req_t exp);
        if (got.word_idx !== exp.word_idx) begin
            $display("error at %0t: %s.word_idx got %h expected %h", $time, name,
                     got.word_idx, exp.word_idx);
            error_count++;
        end
        if (got.data !== exp.data) begin
            $display("error at %0t: %s.data got %h expected %h", $time, name,
                     got.data, exp.data);
            error_count++;
        end
        if (got.strb !== exp.strb) begin
            $display("error at %0t: %s.strb got %h expected %h", $time, name,
                     got.strb, exp.strb);
            error_count++;
        end
        compare_bit({name, ".err"}, got.err, exp.err);
    endtask

    // Records handshakes that complete at the coming rising edge
    always begin
        @(negedge i_clk);
        #MON_DLY;
        if (i_rst_n) begin
            if (i_aw_valid && o_aw_ready) aw_q.push_back(i_aw);
            if (i_w_valid && o_w_ready) w_q.push_back(i_w);
            while (aw_q.size() > 0 && w_q.size() > 0) begin
                mon_aw = aw_q.pop_front();
                mon_w  = w_q.pop_front();
                exp_q.push_back(expect_req(mon_aw, mon_w));
            end
            if (o_req_valid && i_req_ready) begin
                req_count++;
                if (exp_q.size() == 0) begin
                    $display("request accepted at %0t without a matching beat pair", $time);
                    error_count++;
                end else begin
                    compare_req("o_req", o_req, exp_q.pop_front());
                end
            end
        end
    end

    // Entered at a falling edge, returns at the falling edge after acceptance
    task automatic send_aw(input logic [ADDR_W-1:0] addr, input int gap);
        int waited;
        waited = 0;
        repeat (gap) @(negedge i_clk);
        i_aw.addr  = addr;
        i_aw_valid = 1'b1;
        #SAMPLE_DLY;
        while (!o_aw_ready && waited < TIMEOUT) begin
            @(negedge i_clk);
            #SAMPLE_DLY;
            waited++;
        end
        if (!o_aw_ready) begin
            $display("timeout: address beat %h not accepted in %0d cycles", addr, TIMEOUT);
            error_count++;
        end
        @(negedge i_clk);
        i_aw_valid = 1'b0;
    endtask

    task automatic send_w(input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                          input int gap);
        int waited;
        waited = 0;
        repeat (gap) @(negedge i_clk);
        i_w.data  = data;
        i_w.strb  = strb;
        i_w_valid = 1'b1;
        #SAMPLE_DLY;
        while (!o_w_ready && waited < TIMEOUT) begin
            @(negedge i_clk);
            #SAMPLE_DLY;
            waited++;
        end
        if (!o_w_ready) begin
            $display("timeout: data beat %h not accepted in %0d cycles", data, TIMEOUT);
            error_count++;
        end
        @(negedge i_clk);
        i_w_valid = 1'b0;
    endtask

    task automatic check_flags(input logic aw_rdy, input logic w_rdy, input logic req_vld);
        #SAMPLE_DLY;
        compare_bit("o_aw_ready", o_aw_ready, aw_rdy);
        compare_bit("o_w_ready", o_w_ready, w_rdy);
        compare_bit("o_req_valid", o_req_valid, req_vld);
        @(negedge i_clk);
    endtask

    // Until every accepted beat has left as a request
    task automatic wait_drained(input string what);
        int waited;
        waited = 0;
        #SAMPLE_DLY;
        while ((o_req_valid || aw_q.size() != 0 || w_q.size() != 0 || exp_q.size() != 0)
               && waited < TIMEOUT) begin
            @(negedge i_clk);
            #SAMPLE_DLY;
            waited++;
        end
        if (o_req_valid || aw_q.size() != 0 || w_q.size() != 0 || exp_q.size() != 0) begin
            $display("timeout: %s did not drain in %0d cycles", what, TIMEOUT);
            error_count++;
        end
        @(negedge i_clk);
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (error_count == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: FAIL, %0d errors", name, error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    task automatic test_reset_and_forward();
        wr_req_t exp;
        check_flags(1'b1, 1'b1, 1'b0);       // Idle after reset
        exp.word_idx = 10'h049;              // Byte address 0x124
        exp.data     = 32'hA5A5_0001;
        exp.strb     = 4'hF;
        exp.err      = 1'b0;
        i_aw.addr    = 12'h124;
        i_aw_valid   = 1'b1;
        i_w.data     = 32'hA5A5_0001;
        i_w.strb     = 4'hF;
        i_w_valid    = 1'b1;
        i_req_ready  = 1'b1;
        #SAMPLE_DLY;
        compare_bit("o_req_valid", o_req_valid, 1'b1);  // Same cycle, both FIFOs bypassed
        compare_req("o_req", o_req, exp);
        @(negedge i_clk);
        i_aw_valid  = 1'b0;
        i_w_valid   = 1'b0;
        i_req_ready = 1'b0;
        check_flags(1'b1, 1'b1, 1'b0);       // Nothing left behind
        report_test("reset and forwarding");
    endtask

    task automatic test_skewed_channels();
        i_req_ready = 1'b1;
        send_aw(12'h010, 0);
        send_aw(12'h024, 0);
        send_aw(12'h7F0, 0);
        check_flags(1'b0, 1'b1, 1'b0);       // Address FIFO full, no data yet
        repeat (3) @(negedge i_clk);
        send_w(32'h1111_0000, 4'hF, 0);
        send_w(32'h2222_0000, 4'h3, 1);
        send_w(32'h3333_0000, 4'hC, 2);
        wait_drained("skewed channels");
        check_flags(1'b1, 1'b1, 1'b0);
        report_test("skewed channels");
    endtask

    task automatic test_back_pressure();
        i_req_ready = 1'b0;
        send_aw(12'h100, 0);
        send_aw(12'h104, 0);
        check_flags(1'b1, 1'b1, 1'b0);
        send_aw(12'h108, 0);
        check_flags(1'b0, 1'b1, 1'b0);       // 3 addresses stored
        send_w(32'hB000_0001, 4'h1, 0);
        check_flags(1'b0, 1'b1, 1'b1);
        send_w(32'hB000_0002, 4'h2, 0);
        check_flags(1'b0, 1'b0, 1'b1);       // 2 data beats stored
        i_req_ready = 1'b1;
        send_w(32'hB000_0003, 4'h4, 0);
        wait_drained("back pressure");
        check_flags(1'b1, 1'b1, 1'b0);
        report_test("back pressure");
    endtask

    task automatic test_error_decode();
        logic [ADDR_W-1:0] addr[4];
        logic              err_exp[4];
        addr[0]    = 12'h102;                // Misaligned inside the window
        err_exp[0] = 1'b1;
        addr[1]    = WINDOW_LIMIT;
        err_exp[1] = 1'b1;
        addr[2]    = WINDOW_LIMIT + 12'd4;
        err_exp[2] = 1'b1;
        addr[3]    = WINDOW_LIMIT - 12'd4;   // Last word of the window
        err_exp[3] = 1'b0;
        for (int k = 0; k < 4; k++) begin
            i_req_ready = 1'b0;
            fork
                send_aw(addr[k], 0);
                send_w(32'hE000_0000 + k, 4'hF, 0);
            join
            #SAMPLE_DLY;
            compare_bit("o_req_valid", o_req_valid, 1'b1);
            compare_bit("o_req.err", o_req.err, err_exp[k]);
            @(negedge i_clk);
            i_req_ready = 1'b1;
            wait_drained("error decode");
        end
        report_test("error decode");
    endtask

    task automatic test_random_traffic();
        int start_reqs;
        int senders_done;
        int cycles;
        start_reqs   = req_count;
        senders_done = 0;
        cycles       = 0;
        fork
            begin
                for (int k = 0; k < RAND_BEATS; k++) begin
                    send_aw(ADDR_W'($urandom), $urandom_range(0, 2));
                end
                senders_done++;
            end
            begin
                for (int k = 0; k < RAND_BEATS; k++) begin
                    send_w($urandom, STRB_W'($urandom), $urandom_range(0, 2));
                end
                senders_done++;
            end
            begin
                // Ready high about three cycles in four
                while (senders_done < 2 && cycles < RAND_BEATS * TIMEOUT) begin
                    i_req_ready = ($urandom_range(0, 3) != 0);
                    @(negedge i_clk);
                    cycles++;
                end
            end
        join
        i_req_ready = 1'b1;
        wait_drained("random traffic");
        if (req_count - start_reqs != RAND_BEATS) begin
            $display("random traffic gave %0d requests for %0d beat pairs",
                     req_count - start_reqs, RAND_BEATS);
            error_count++;
        end
        report_test("random traffic");
    endtask

    initial begin
        void'($urandom(89));
        i_rst_n           = 1'b0;
        i_aw              = '0;
        i_aw_valid        = 1'b0;
        i_w               = '0;
        i_w_valid         = 1'b0;
        i_req_ready       = 1'b0;
        error_count       = 0;
        req_count         = 0;
        test_count        = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        repeat (5) @(negedge i_clk);
        i_rst_n = 1'b1;

        test_reset_and_forward();
        test_skewed_channels();
        test_back_pressure();
        test_error_decode();
        test_random_traffic();

        $display("summary: %0d tests run, %0d with errors, %0d mismatches, %0d requests",
                 test_count, failed_tests, error_count, req_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : wr_join_tb

`default_nettype wire

// ==== sources.f ====
hw/wr_join_pkg.sv
hw/fifo_0r0w.sv
hw/write_joiner.sv
hw/wr_join_top.sv
sim/wr_join_assertions.sv
sim/wr_join_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the write join testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module wr_join_tb -f sources.f -o wr_join_sim \
    || { echo "verilator build error"; exit 1; }

sim_out=$(./obj_dir/wr_join_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "all tests passed" && exit 0 || exit 1
